//--- Makefile
SRCS = soc_settings.svh axi_pkg.sv axi_lite_if.sv axi_arbiter.sv axi_xbar.sv \
       axi_sram.sv axi_uart.sv axi_clint.sv soc_bus_top.sv tb_clock.sv tb_soc_bus.sv

obj_dir/Vtb_soc_bus: sources.f $(SRCS)
	verilator --binary --timing --top-module tb_soc_bus -f sources.f

.PHONY: run clean
run: obj_dir/Vtb_soc_bus
	@out=$$(./obj_dir/Vtb_soc_bus); echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- axi_arbiter.sv
module axi_arbiter (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave ifu,
    axi_lite_if.slave lsu,
    axi_lite_if.master m
);

    // 0 selects ifu, 1 selects lsu
    logic busy;
    logic gnt;
    logic last;
    logic sel;
    logic ifu_req;
    logic lsu_req;
    logic addr_hs;
    logic resp_hs;

    assign ifu_req = ifu.arvalid || ifu.awvalid;
    assign lsu_req = lsu.arvalid || lsu.awvalid;

    // held grant wins, otherwise pick combinationally
    always_comb begin
        if (busy) begin
            sel = gnt;
        end else if (ifu_req && lsu_req) begin
            sel = ~last;
        end else begin
            sel = lsu_req;
        end
    end

    // request side
    assign m.araddr  = sel ? lsu.araddr  : ifu.araddr;
    assign m.arvalid = sel ? lsu.arvalid : ifu.arvalid;
    assign m.rready  = sel ? lsu.rready  : ifu.rready;
    assign m.awaddr  = sel ? lsu.awaddr  : ifu.awaddr;
    assign m.awvalid = sel ? lsu.awvalid : ifu.awvalid;
    assign m.wdata   = sel ? lsu.wdata   : ifu.wdata;
    assign m.wstrb   = sel ? lsu.wstrb   : ifu.wstrb;
    assign m.wvalid  = sel ? lsu.wvalid  : ifu.wvalid;
    assign m.bready  = sel ? lsu.bready  : ifu.bready;

    // the master without the grant sees no ready or valid
    assign ifu.arready = !sel && m.arready;
    assign lsu.arready = sel && m.arready;
    assign ifu.awready = !sel && m.awready;
    assign lsu.awready = sel && m.awready;
    assign ifu.wready  = !sel && m.wready;
    assign lsu.wready  = sel && m.wready;
    assign ifu.rvalid  = !sel && m.rvalid;
    assign lsu.rvalid  = sel && m.rvalid;
    assign ifu.bvalid  = !sel && m.bvalid;
    assign lsu.bvalid  = sel && m.bvalid;

    // payloads are shared, qualified by valid
    assign ifu.rdata = m.rdata;
    assign lsu.rdata = m.rdata;
    assign ifu.rresp = m.rresp;
    assign lsu.rresp = m.rresp;
    assign ifu.bresp = m.bresp;
    assign lsu.bresp = m.bresp;

    assign addr_hs = (m.arvalid && m.arready) || (m.awvalid && m.awready);
    assign resp_hs = (m.rvalid && m.rready) || (m.bvalid && m.bready);

    // lock at the address handshake, free at the response handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            gnt  <= 1'b0;
            last <= 1'b1;
        end else if (busy && resp_hs) begin
            busy <= 1'b0;
            last <= gnt;
        end else if (!busy && addr_hs) begin
            busy <= 1'b1;
            gnt  <= sel;
        end
    end

endmodule

//--- axi_clint.sv
`include "soc_settings.svh"

module axi_clint (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave s,
    output logic timer_irq
);
    import axi_pkg::*;

    logic [`SOC_DATA_W-1:0] mtime;
    logic [`SOC_DATA_W-1:0] mtimecmp;
    logic ar_hs;
    logic aw_hs;

    assign ar_hs = s.arvalid && s.arready;
    assign aw_hs = s.awvalid && s.awready;

    assign s.awready = s.awvalid && s.wvalid && !s.bvalid;
    assign s.wready = s.awready;
    assign s.rresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s.arready <= 1'b0;
            s.rvalid  <= 1'b0;
            s.bvalid  <= 1'b0;
        end else begin
            s.arready <= !(ar_hs || (s.rvalid && !s.rready));
            if (ar_hs) begin
                s.rvalid <= 1'b1;
            end else if (s.rready) begin
                s.rvalid <= 1'b0;
            end
            if (aw_hs) begin
                s.bvalid <= 1'b1;
            end else if (s.bready) begin
                s.bvalid <= 1'b0;
            end
        end
    end

    // timer state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            mtime <= mtime + 1'b1;
            timer_irq <= (mtime >= mtimecmp);
            if (aw_hs && s.awaddr == `SOC_MTIMECMP_ADDR) begin
                mtimecmp <= strb_merge(mtimecmp, s.wdata, s.wstrb);
            end
        end
    end

    // mtime is read only, a write there is refused
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s.rdata <= (s.araddr == `SOC_MTIME_ADDR) ? mtime : mtimecmp;
        end
        if (aw_hs) begin
            s.bresp <= (s.awaddr == `SOC_MTIME_ADDR) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

//--- axi_lite_if.sv
`include "soc_settings.svh"

interface axi_lite_if;
    import axi_pkg::*;

    // read address
    logic [`SOC_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    // read data
    logic [`SOC_DATA_W-1:0] rdata;
    axi_resp_t rresp;
    logic rvalid;
    logic rready;
    // write address
    logic [`SOC_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    // write data
    logic [`SOC_DATA_W-1:0] wdata;
    logic [axi_strb_w-1:0] wstrb;
    logic wvalid;
    logic wready;
    // write response
    axi_resp_t bresp;
    logic bvalid;
    logic bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

//--- axi_pkg.sv
`include "soc_settings.svh"

package axi_pkg;

    localparam int axi_strb_w = `SOC_DATA_W / 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // crossbar routing target
    typedef enum logic [1:0] {
        SEL_SRAM,
        SEL_UART,
        SEL_CLINT
    } slave_sel_t;

    // byte lanes with strobe set take the new data
    function automatic logic [`SOC_DATA_W-1:0] strb_merge(
        input logic [`SOC_DATA_W-1:0] old_word,
        input logic [`SOC_DATA_W-1:0] new_word,
        input logic [axi_strb_w-1:0] strb
    );
        logic [`SOC_DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < axi_strb_w; i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- axi_sram.sv
`include "soc_settings.svh"

module axi_sram (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave s
);
    import axi_pkg::*;

    localparam int offset_w = $clog2(axi_strb_w);
    localparam int index_w = $clog2(`SOC_SRAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
    logic [index_w-1:0] wr_idx;
    logic ar_hs;
    logic aw_hs;

    assign ar_hs = s.arvalid && s.arready;
    assign aw_hs = s.awvalid && s.awready;
    assign wr_idx = s.awaddr[offset_w +: index_w];

    // address and data are taken together
    assign s.awready = s.awvalid && s.wvalid && !s.bvalid;
    assign s.wready = s.awready;
    assign s.rresp = RESP_OKAY;
    assign s.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s.arready <= 1'b0;
            s.rvalid  <= 1'b0;
            s.bvalid  <= 1'b0;
        end else begin
            // no new read while a response waits
            s.arready <= !(ar_hs || (s.rvalid && !s.rready));
            if (ar_hs) begin
                s.rvalid <= 1'b1;
            end else if (s.rready) begin
                s.rvalid <= 1'b0;
            end
            if (aw_hs) begin
                s.bvalid <= 1'b1;
            end else if (s.bready) begin
                s.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s.rdata <= mem[s.araddr[offset_w +: index_w]];
        end
        if (aw_hs) begin
            mem[wr_idx] <= strb_merge(mem[wr_idx], s.wdata, s.wstrb);
        end
    end

endmodule

//--- axi_uart.sv
module axi_uart (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave s,
    output logic [7:0] tx_byte,
    output logic tx_valid
);
    import axi_pkg::*;

    logic ar_hs;
    logic aw_hs;

    assign ar_hs = s.arvalid && s.arready;
    assign aw_hs = s.awvalid && s.awready;

    assign s.awready = s.awvalid && s.wvalid && !s.bvalid;
    assign s.wready = s.awready;
    // receive side is always empty
    assign s.rdata = '0;
    assign s.rresp = RESP_OKAY;
    assign s.bresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s.arready <= 1'b0;
            s.rvalid  <= 1'b0;
            s.bvalid  <= 1'b0;
            tx_valid  <= 1'b0;
        end else begin
            s.arready <= !(ar_hs || (s.rvalid && !s.rready));
            if (ar_hs) begin
                s.rvalid <= 1'b1;
            end else if (s.rready) begin
                s.rvalid <= 1'b0;
            end
            if (aw_hs) begin
                s.bvalid <= 1'b1;
            end else if (s.bready) begin
                s.bvalid <= 1'b0;
            end
            // one pulse per accepted byte, same edge as bvalid
            tx_valid <= aw_hs && s.wstrb[0];
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs && s.wstrb[0]) begin
            tx_byte <= s.wdata[7:0];
        end
    end

endmodule

//--- axi_xbar.sv
`include "soc_settings.svh"

module axi_xbar (
    input logic clk,
    input logic rst_n,
    axi_lite_if.slave m,
    axi_lite_if.master sram,
    axi_lite_if.master uart,
    axi_lite_if.master clint
);
    import axi_pkg::*;

    slave_sel_t ar_sel;
    slave_sel_t aw_sel;
    slave_sel_t r_sel;
    slave_sel_t b_sel;

    // anything not a device register falls through to sram
    function automatic slave_sel_t decode(input logic [`SOC_ADDR_W-1:0] addr);
        if (addr == `SOC_UART_ADDR) begin
            return SEL_UART;
        end
        if (addr == `SOC_MTIME_ADDR || addr == `SOC_MTIMECMP_ADDR) begin
            return SEL_CLINT;
        end
        return SEL_SRAM;
    endfunction

    assign ar_sel = decode(m.araddr);
    assign aw_sel = decode(m.awaddr);

    // read requests, idle slaves get zeros
    assign sram.araddr   = (ar_sel == SEL_SRAM) ? m.araddr : '0;
    assign uart.araddr   = (ar_sel == SEL_UART) ? m.araddr : '0;
    assign clint.araddr  = (ar_sel == SEL_CLINT) ? m.araddr : '0;
    assign sram.arvalid  = (ar_sel == SEL_SRAM) && m.arvalid;
    assign uart.arvalid  = (ar_sel == SEL_UART) && m.arvalid;
    assign clint.arvalid = (ar_sel == SEL_CLINT) && m.arvalid;
    assign sram.rready   = (r_sel == SEL_SRAM) && m.rready;
    assign uart.rready   = (r_sel == SEL_UART) && m.rready;
    assign clint.rready  = (r_sel == SEL_CLINT) && m.rready;

    // write requests
    assign sram.awaddr   = (aw_sel == SEL_SRAM) ? m.awaddr : '0;
    assign uart.awaddr   = (aw_sel == SEL_UART) ? m.awaddr : '0;
    assign clint.awaddr  = (aw_sel == SEL_CLINT) ? m.awaddr : '0;
    assign sram.awvalid  = (aw_sel == SEL_SRAM) && m.awvalid;
    assign uart.awvalid  = (aw_sel == SEL_UART) && m.awvalid;
    assign clint.awvalid = (aw_sel == SEL_CLINT) && m.awvalid;
    assign sram.wdata    = (aw_sel == SEL_SRAM) ? m.wdata : '0;
    assign uart.wdata    = (aw_sel == SEL_UART) ? m.wdata : '0;
    assign clint.wdata   = (aw_sel == SEL_CLINT) ? m.wdata : '0;
    assign sram.wstrb    = (aw_sel == SEL_SRAM) ? m.wstrb : '0;
    assign uart.wstrb    = (aw_sel == SEL_UART) ? m.wstrb : '0;
    assign clint.wstrb   = (aw_sel == SEL_CLINT) ? m.wstrb : '0;
    assign sram.wvalid   = (aw_sel == SEL_SRAM) && m.wvalid;
    assign uart.wvalid   = (aw_sel == SEL_UART) && m.wvalid;
    assign clint.wvalid  = (aw_sel == SEL_CLINT) && m.wvalid;
    assign sram.bready   = (b_sel == SEL_SRAM) && m.bready;
    assign uart.bready   = (b_sel == SEL_UART) && m.bready;
    assign clint.bready  = (b_sel == SEL_CLINT) && m.bready;

    // address readies follow the live decode
    assign m.arready = (ar_sel == SEL_UART)  ? uart.arready :
                       (ar_sel == SEL_CLINT) ? clint.arready : sram.arready;
    assign m.awready = (aw_sel == SEL_UART)  ? uart.awready :
                       (aw_sel == SEL_CLINT) ? clint.awready : sram.awready;
    assign m.wready  = (aw_sel == SEL_UART)  ? uart.wready :
                       (aw_sel == SEL_CLINT) ? clint.wready : sram.wready;

    // responses follow the captured route
    assign m.rdata  = (r_sel == SEL_UART)  ? uart.rdata :
                      (r_sel == SEL_CLINT) ? clint.rdata : sram.rdata;
    assign m.rresp  = (r_sel == SEL_UART)  ? uart.rresp :
                      (r_sel == SEL_CLINT) ? clint.rresp : sram.rresp;
    assign m.rvalid = (r_sel == SEL_UART)  ? uart.rvalid :
                      (r_sel == SEL_CLINT) ? clint.rvalid : sram.rvalid;
    assign m.bresp  = (b_sel == SEL_UART)  ? uart.bresp :
                      (b_sel == SEL_CLINT) ? clint.bresp : sram.bresp;
    assign m.bvalid = (b_sel == SEL_UART)  ? uart.bvalid :
                      (b_sel == SEL_CLINT) ? clint.bvalid : sram.bvalid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_sel <= SEL_SRAM;
            b_sel <= SEL_SRAM;
        end else begin
            if (m.arvalid && m.arready) begin
                r_sel <= ar_sel;
            end
            if (m.awvalid && m.awready) begin
                b_sel <= aw_sel;
            end
        end
    end

endmodule

//--- soc_bus_top.sv
`include "soc_settings.svh"

module soc_bus_top (
    input logic clk,
    input logic rst_n,
    // instruction fetch master
    input logic [`SOC_ADDR_W-1:0] ifu_araddr,
    input logic ifu_arvalid,
    output logic ifu_arready,
    output logic [`SOC_DATA_W-1:0] ifu_rdata,
    output axi_pkg::axi_resp_t ifu_rresp,
    output logic ifu_rvalid,
    input logic ifu_rready,
    input logic [`SOC_ADDR_W-1:0] ifu_awaddr,
    input logic ifu_awvalid,
    output logic ifu_awready,
    input logic [`SOC_DATA_W-1:0] ifu_wdata,
    input logic [axi_pkg::axi_strb_w-1:0] ifu_wstrb,
    input logic ifu_wvalid,
    output logic ifu_wready,
    output axi_pkg::axi_resp_t ifu_bresp,
    output logic ifu_bvalid,
    input logic ifu_bready,
    // load store master
    input logic [`SOC_ADDR_W-1:0] lsu_araddr,
    input logic lsu_arvalid,
    output logic lsu_arready,
    output logic [`SOC_DATA_W-1:0] lsu_rdata,
    output axi_pkg::axi_resp_t lsu_rresp,
    output logic lsu_rvalid,
    input logic lsu_rready,
    input logic [`SOC_ADDR_W-1:0] lsu_awaddr,
    input logic lsu_awvalid,
    output logic lsu_awready,
    input logic [`SOC_DATA_W-1:0] lsu_wdata,
    input logic [axi_pkg::axi_strb_w-1:0] lsu_wstrb,
    input logic lsu_wvalid,
    output logic lsu_wready,
    output axi_pkg::axi_resp_t lsu_bresp,
    output logic lsu_bvalid,
    input logic lsu_bready,
    // devices
    output logic [7:0] tx_byte,
    output logic tx_valid,
    output logic timer_irq
);

    axi_lite_if ifu_bus ();
    axi_lite_if lsu_bus ();
    axi_lite_if m_bus ();
    axi_lite_if sram_bus ();
    axi_lite_if uart_bus ();
    axi_lite_if clint_bus ();

    // ifu pins onto its bus
    assign ifu_bus.araddr  = ifu_araddr;
    assign ifu_bus.arvalid = ifu_arvalid;
    assign ifu_bus.rready  = ifu_rready;
    assign ifu_bus.awaddr  = ifu_awaddr;
    assign ifu_bus.awvalid = ifu_awvalid;
    assign ifu_bus.wdata   = ifu_wdata;
    assign ifu_bus.wstrb   = ifu_wstrb;
    assign ifu_bus.wvalid  = ifu_wvalid;
    assign ifu_bus.bready  = ifu_bready;
    assign ifu_arready = ifu_bus.arready;
    assign ifu_rdata   = ifu_bus.rdata;
    assign ifu_rresp   = ifu_bus.rresp;
    assign ifu_rvalid  = ifu_bus.rvalid;
    assign ifu_awready = ifu_bus.awready;
    assign ifu_wready  = ifu_bus.wready;
    assign ifu_bresp   = ifu_bus.bresp;
    assign ifu_bvalid  = ifu_bus.bvalid;

    // lsu pins onto its bus
    assign lsu_bus.araddr  = lsu_araddr;
    assign lsu_bus.arvalid = lsu_arvalid;
    assign lsu_bus.rready  = lsu_rready;
    assign lsu_bus.awaddr  = lsu_awaddr;
    assign lsu_bus.awvalid = lsu_awvalid;
    assign lsu_bus.wdata   = lsu_wdata;
    assign lsu_bus.wstrb   = lsu_wstrb;
    assign lsu_bus.wvalid  = lsu_wvalid;
    assign lsu_bus.bready  = lsu_bready;
    assign lsu_arready = lsu_bus.arready;
    assign lsu_rdata   = lsu_bus.rdata;
    assign lsu_rresp   = lsu_bus.rresp;
    assign lsu_rvalid  = lsu_bus.rvalid;
    assign lsu_awready = lsu_bus.awready;
    assign lsu_wready  = lsu_bus.wready;
    assign lsu_bresp   = lsu_bus.bresp;
    assign lsu_bvalid  = lsu_bus.bvalid;

    axi_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .ifu   (ifu_bus),
        .lsu   (lsu_bus),
        .m     (m_bus)
    );

    axi_xbar u_xbar (
        .clk   (clk),
        .rst_n (rst_n),
        .m     (m_bus),
        .sram  (sram_bus),
        .uart  (uart_bus),
        .clint (clint_bus)
    );

    axi_sram u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .s     (sram_bus)
    );

    axi_uart u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .s        (uart_bus),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid)
    );

    axi_clint u_clint (
        .clk       (clk),
        .rst_n     (rst_n),
        .s         (clint_bus),
        .timer_irq (timer_irq)
    );

endmodule

//--- soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// sram depth in words, index wraps
`define SOC_SRAM_WORDS 256

// uart transmit register
`define SOC_UART_ADDR 32'ha000_03f8

// clint timer registers
`define SOC_MTIME_ADDR 32'ha000_0048
`define SOC_MTIMECMP_ADDR 32'ha000_0050

`endif

//--- sources.f
+incdir+.
axi_pkg.sv
axi_lite_if.sv
axi_arbiter.sv
axi_xbar.sv
axi_sram.sv
axi_uart.sv
axi_clint.sv
soc_bus_top.sv
tb_clock.sv
tb_soc_bus.sv

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low for five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- tb_soc_bus.sv
`include "soc_settings.svh"

module tb_soc_bus;
    import axi_pkg::*;

    localparam int n_rand = 40;
    localparam int n_txn = 2 * n_rand + 16;
    localparam int cycle_limit = 20 * n_txn + 200;

    logic clk;
    logic rst_n;
    // index 0 is the ifu port and index 1 the lsu port
    logic [31:0] araddr [2];
    logic arvalid [2];
    logic arready [2];
    logic [31:0] rdata [2];
    logic [1:0] rresp [2];
    logic rvalid [2];
    logic rready [2];
    logic [31:0] awaddr [2];
    logic awvalid [2];
    logic awready [2];
    logic [31:0] wdata [2];
    logic [3:0] wstrb [2];
    logic wvalid [2];
    logic wready [2];
    logic [1:0] bresp [2];
    logic bvalid [2];
    logic bready [2];
    logic [7:0] tx_byte;
    logic tx_valid;
    logic timer_irq;

    logic [31:0] lfsr [2];
    logic [31:0] model [`SOC_SRAM_WORDS];
    logic [3:0] known [`SOC_SRAM_WORDS];
    int done_cnt [2];
    int cycles;
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] mask_q [$];
    string what_q [$];
    logic [7:0] tx_q [$];
    logic [7:0] sent_q [$];

    tb_clock clkgen (.clk(clk), .rst_n(rst_n));

    soc_bus_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .ifu_araddr(araddr[0]), .ifu_arvalid(arvalid[0]), .ifu_arready(arready[0]),
        .ifu_rdata(rdata[0]), .ifu_rresp(rresp[0]), .ifu_rvalid(rvalid[0]),
        .ifu_rready(rready[0]), .ifu_awaddr(awaddr[0]), .ifu_awvalid(awvalid[0]),
        .ifu_awready(awready[0]), .ifu_wdata(wdata[0]), .ifu_wstrb(wstrb[0]),
        .ifu_wvalid(wvalid[0]), .ifu_wready(wready[0]), .ifu_bresp(bresp[0]),
        .ifu_bvalid(bvalid[0]), .ifu_bready(bready[0]),
        .lsu_araddr(araddr[1]), .lsu_arvalid(arvalid[1]), .lsu_arready(arready[1]),
        .lsu_rdata(rdata[1]), .lsu_rresp(rresp[1]), .lsu_rvalid(rvalid[1]),
        .lsu_rready(rready[1]), .lsu_awaddr(awaddr[1]), .lsu_awvalid(awvalid[1]),
        .lsu_awready(awready[1]), .lsu_wdata(wdata[1]), .lsu_wstrb(wstrb[1]),
        .lsu_wvalid(wvalid[1]), .lsu_wready(wready[1]), .lsu_bresp(bresp[1]),
        .lsu_bvalid(bvalid[1]), .lsu_bready(bready[1]),
        .tx_byte(tx_byte), .tx_valid(tx_valid), .timer_irq(timer_irq)
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int m, input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[m][31] ^ lfsr[m][21] ^ lfsr[m][1] ^ lfsr[m][0];
            lfsr[m] = {lfsr[m][30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) r[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] k);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) r[i*8 +: 8] = {8{k[i]}};
        return r;
    endfunction

    // reference read data for an sram word
    function automatic logic [31:0] exp_word(input int idx);
        return model[idx];
    endfunction

    task automatic stop_failed(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_failed($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
    endtask

    task automatic post_check(input logic [31:0] g, input logic [31:0] e,
                              input logic [31:0] mk, input string what);
        got_q.push_back(g);
        exp_q.push_back(e);
        mask_q.push_back(mk);
        what_q.push_back(what);
    endtask

    task automatic write_txn(input int m, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall,
                             output logic [1:0] resp);
        int start;
        start = done_cnt[1-m];
        awaddr[m] <= addr;
        wdata[m] <= data;
        wstrb[m] <= strb;
        awvalid[m] <= 1'b1;
        wvalid[m] <= 1'b1;
        do @(posedge clk); while (!awready[m]);
        assert (wready[m])
            else report_mismatch("wready low on the edge that accepted the write address");
        assert (done_cnt[1-m] - start <= 1)
            else stop_failed("arbiter let the other master run twice during one wait");
        #1 awvalid[m] <= 1'b0;
        wvalid[m] <= 1'b0;
        do @(posedge clk); while (!bvalid[m]);
        resp = bresp[m];
        repeat (stall) begin
            @(posedge clk);
            assert (bvalid[m] && bresp[m] == resp)
                else report_mismatch("write response dropped or changed under back-pressure");
        end
        #1 bready[m] <= 1'b1;
        @(posedge clk);
        done_cnt[m]++;
        #1 bready[m] <= 1'b0;
    endtask

    task automatic read_txn(input int m, input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        int start;
        start = done_cnt[1-m];
        araddr[m] <= addr;
        arvalid[m] <= 1'b1;
        do @(posedge clk); while (!arready[m]);
        assert (done_cnt[1-m] - start <= 1)
            else stop_failed("arbiter let the other master run twice during one wait");
        #1 arvalid[m] <= 1'b0;
        do @(posedge clk); while (!rvalid[m]);
        data = rdata[m];
        resp = rresp[m];
        repeat (stall) begin
            @(posedge clk);
            assert (rvalid[m] && rdata[m] == data)
                else report_mismatch("read data dropped or changed under back-pressure");
        end
        #1 rready[m] <= 1'b1;
        @(posedge clk);
        done_cnt[m]++;
        #1 rready[m] <= 1'b0;
    endtask

    // random strobed sram traffic inside the master's own half
    task automatic run_master(input int m);
        int idx;
        logic [31:0] addr;
        logic [31:0] d;
        logic [31:0] e;
        logic [3:0] strb;
        logic [1:0] resp;
        logic is_wr;
        int stall;
        for (int k = 0; k < n_rand; k++) begin
            idx = m * 128 + int'(take_bits(m, 7));
            addr = 32'(idx) << 2;
            is_wr = take_bits(m, 1) != 0;
            stall = int'(take_bits(m, 2));
            if (is_wr) begin
                d = take_bits(m, 32);
                strb = 4'(take_bits(m, 4));
                write_txn(m, addr, d, strb, stall, resp);
                post_check({30'b0, resp}, 32'd0, '1, "sram write response");
                model[idx] = merge_bytes(model[idx], d, strb);
                known[idx] = known[idx] | strb;
            end else begin
                e = exp_word(idx);
                read_txn(m, addr, stall, d, resp);
                post_check(d, e, byte_mask(known[idx]), "sram read data");
                post_check({30'b0, resp}, 32'd0, '1, "sram read response");
            end
        end
    endtask

    // comparing process
    always @(posedge clk) begin : compare
        logic [31:0] g;
        logic [31:0] e;
        logic [31:0] mk;
        string what;
        while (got_q.size() > 0) begin
            g = got_q.pop_front();
            e = exp_q.pop_front();
            mk = mask_q.pop_front();
            what = what_q.pop_front();
            assert ((g & mk) == (e & mk))
                else report_mismatch($sformatf("%s got %h expected %h",
                                               what, g & mk, e & mk));
        end
    end

    always @(posedge clk) begin
        if (tx_valid) tx_q.push_back(tx_byte);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) stop_failed("timeout: DUT stopped responding");
    end

    initial begin : stimulus
        logic [31:0] d;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] cmp;
        logic [7:0] b;
        logic [1:0] resp;
        int waited;
        lfsr[0] = 32'h12e2_26ea;
        lfsr[1] = 32'h12e2_26ea;
        cycles = 0;
        done_cnt[0] = 0;
        done_cnt[1] = 0;
        for (int i = 0; i < `SOC_SRAM_WORDS; i++) known[i] = 4'h0;
        for (int m = 0; m < 2; m++) begin
            araddr[m] <= '0;
            arvalid[m] <= 1'b0;
            rready[m] <= 1'b0;
            awaddr[m] <= '0;
            awvalid[m] <= 1'b0;
            wdata[m] <= '0;
            wstrb[m] <= '0;
            wvalid[m] <= 1'b0;
            bready[m] <= 1'b0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        assert (!timer_irq && !tx_valid) else report_mismatch("outputs not low after reset");
        #1;
        fork
            run_master(0);
            run_master(1);
        join

        // uart writes from the lsu
        // word 254 is the sram alias of the uart address
        write_txn(1, 32'h0000_03f8, 32'h5a5a_c3c3, 4'hf, 0, resp);
        model[254] = 32'h5a5a_c3c3;
        known[254] = 4'hf;
        for (int i = 0; i < 4; i++) begin
            b = 8'(take_bits(1, 8));
            d = {24'(take_bits(1, 24)), b};
            write_txn(1, `SOC_UART_ADDR, d, 4'h1, i, resp);
            sent_q.push_back(b);
            post_check({30'b0, resp}, 32'd0, '1, "uart write response");
        end
        repeat (2) @(posedge clk);
        #1 post_check(32'(tx_q.size()), 32'(sent_q.size()), '1, "uart byte count");
        while (tx_q.size() > 0 && sent_q.size() > 0) begin
            post_check({24'b0, tx_q.pop_front()}, {24'b0, sent_q.pop_front()}, '1,
                       "uart byte");
        end
        read_txn(1, `SOC_UART_ADDR, 1, d, resp);
        post_check(d, 32'd0, '1, "uart read data");
        post_check({30'b0, resp}, 32'd0, '1, "uart read response");
        read_txn(1, 32'h0000_03f8, 0, d, resp);
        post_check(d, exp_word(254), '1, "sram word behind uart alias");

        // clint from the ifu
        read_txn(0, `SOC_MTIME_ADDR, 0, t1, resp);
        read_txn(0, `SOC_MTIME_ADDR, 2, t2, resp);
        assert (t2 > t1) else report_mismatch("mtime did not increase between reads");
        write_txn(0, `SOC_MTIME_ADDR, 32'h0, 4'hf, 0, resp);
        post_check({30'b0, resp}, 32'd2, '1, "mtime write response");
        write_txn(0, `SOC_MTIMECMP_ADDR, 32'h1234_5678, 4'hf, 0, resp);
        post_check({30'b0, resp}, 32'd0, '1, "mtimecmp write response");
        write_txn(0, `SOC_MTIMECMP_ADDR, 32'haabb_ccdd, 4'b0101, 1, resp);
        cmp = merge_bytes(merge_bytes('1, 32'h1234_5678, 4'hf), 32'haabb_ccdd, 4'b0101);
        read_txn(0, `SOC_MTIMECMP_ADDR, 0, d, resp);
        post_check(d, cmp, '1, "mtimecmp readback");

        // timer interrupt
        read_txn(0, `SOC_MTIME_ADDR, 0, t1, resp);
        cmp = t1 + 32'd50;
        write_txn(0, `SOC_MTIMECMP_ADDR, cmp, 4'hf, 0, resp);
        assert (!timer_irq)
            else report_mismatch("timer_irq rose before mtime reached mtimecmp");
        waited = 0;
        while (!timer_irq && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        assert (timer_irq) else stop_failed("timer_irq never rose");
        #1 read_txn(0, `SOC_MTIME_ADDR, 0, t2, resp);
        assert (t2 >= cmp) else report_mismatch("mtime below mtimecmp after interrupt");

        repeat (2) @(posedge clk);
        if (got_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_failed("checks left unprocessed at end of run");
        end
    end

endmodule
